// ==== list.f ====
source/decoder_pkg.sv
source/opcode_classifier.sv
source/bus_sequencer.sv
source/datapath_decoder.sv
source/control_register.sv
source/instruction_decoder.sv
bench/decoder_sva.sv
bench/decoder_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module decoder_tb -f list.f -o decoder_sim
./obj_dir/decoder_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi

// ==== bench/decoder_tb.sv ====
`timescale 1ns/1ns

module decoder_tb;

	localparam int test_steps = 160;    // vectors applied by all tests plus margin

	logic                    clk_ph2;
	logic                    rst;
	decoder_pkg::cycle_t     cycle;
	decoder_pkg::opcode_t    ir;
	decoder_pkg::status_t    p;
	logic                    carry;
	logic                    a_sign;
	decoder_pkg::addr_ctrl_t addr_ctrl;
	decoder_pkg::data_ctrl_t data_ctrl;
	logic                    r_nw;
	logic                    i_pc;

	int                      errors;         // failed checks
	logic [31:0]             lfsr;           // random state
	decoder_pkg::opcode_t    kept_ops[$];    // every decoded opcode
	decoder_pkg::opcode_t    branch_ops[$];

	instruction_decoder dut0 (
		.clk_ph2   (clk_ph2),
		.rst       (rst),
		.cycle     (cycle),
		.ir        (ir),
		.p         (p),
		.carry     (carry),
		.a_sign    (a_sign),
		.addr_ctrl (addr_ctrl),
		.data_ctrl (data_ctrl),
		.r_nw      (r_nw),
		.i_pc      (i_pc)
	);

	always #50 clk_ph2 = ~clk_ph2;    // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] bit_at(input int unsigned pos);
		return 32'd1 << pos;
	endfunction

	// pc driven onto both address halves and stepped
	function automatic logic [31:0] fetch_bits();
		return bit_at(decoder_pkg::pcl_adl) | bit_at(decoder_pkg::adl_abl) |
			bit_at(decoder_pkg::pch_adh) | bit_at(decoder_pkg::adh_abh) |
			bit_at(decoder_pkg::i_pcint);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32 22 2 1
	endfunction

	task automatic random_bits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);    // one step per bit
			v = {v[6:0], lfsr[31]};
		end
	endtask

	// new inputs on the rising edge and return at the following falling edge
	task automatic drive_inputs(input decoder_pkg::cycle_t c, input decoder_pkg::opcode_t op,
		input decoder_pkg::status_t pv, input logic cv, input logic sv);
		@(posedge clk_ph2);
		cycle <= c;
		ir <= op;
		p <= pv;
		carry <= cv;
		a_sign <= sv;
		@(negedge clk_ph2);
	endtask

	// decode registered one edge later and sampled mid-cycle
	task automatic apply_vector(input decoder_pkg::cycle_t c, input decoder_pkg::opcode_t op,
		input decoder_pkg::status_t pv, input logic cv, input logic sv);
		drive_inputs(c, op, pv, cv, sv);
		@(negedge clk_ph2);
	endtask

	task automatic compare_strobes(input string what, input logic [31:0] got,
		input logic [31:0] ones, input logic [31:0] zeros);
		if ((got & (ones | zeros)) !== ones) begin
			errors++;
			$display("ERROR %0t: %s, got %h, want set %h, want clear %h",
				$time, what, got, ones, zeros);
		end
	endtask

	task automatic compare_level(input string what, input logic got, input logic want);
		if (got !== want) begin
			errors++;
			$display("ERROR %0t: %s, got %b, want %b", $time, what, got, want);
		end
	endtask

	task automatic expect_idle(input string what);
		compare_strobes({what, " addr_ctrl"}, 32'(addr_ctrl), '0, 32'h0001ffff);
		compare_strobes({what, " data_ctrl"}, 32'(data_ctrl), '0, 32'hffffffff);
		compare_level({what, " r_nw"}, r_nw, 1'b1);    // idle means read
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic reset_state();
		repeat (2) @(posedge clk_ph2);    // two edges with rst low
		rst <= 1'b1;
		@(negedge clk_ph2);
		expect_idle("after reset");
	endtask

	task automatic compare_operand(input decoder_pkg::opcode_t op, input int unsigned reg_bit);
		logic [31:0] regs;
		regs = bit_at(decoder_pkg::ac_sb) | bit_at(decoder_pkg::x_sb) | bit_at(decoder_pkg::y_sb);
		apply_vector(3'd1, op, '0, 1'b0, 1'b0);
		compare_strobes($sformatf("compare %h cycle 1 addr", op), 32'(addr_ctrl),
			bit_at(decoder_pkg::r_cycle), bit_at(decoder_pkg::i_cycle));
		compare_strobes($sformatf("compare %h cycle 1 data", op), 32'(data_ctrl),
			bit_at(decoder_pkg::ndb_add) | bit_at(decoder_pkg::c_one) | bit_at(reg_bit),
			(regs & ~bit_at(reg_bit)) | bit_at(decoder_pkg::db_add));    // reg minus operand
	endtask

	task automatic fetch_and_arith();
		logic [31:0] arith_wb;
		int i;
		arith_wb = bit_at(decoder_pkg::add_sb) | bit_at(decoder_pkg::sb_ac) |
			bit_at(decoder_pkg::sb_db) | bit_at(decoder_pkg::avr_v) |
			bit_at(decoder_pkg::acr_c) | bit_at(decoder_pkg::dbz_z) | bit_at(decoder_pkg::db7_n);
		for (i = 0; i < kept_ops.size(); i++) begin
			apply_vector(3'd0, kept_ops[i], '0, 1'b0, 1'b0);
			compare_strobes($sformatf("op %h cycle 0 fetch", kept_ops[i]), 32'(addr_ctrl),
				fetch_bits() | bit_at(decoder_pkg::i_cycle), bit_at(decoder_pkg::r_cycle));
			if (kept_ops[i] == decoder_pkg::adc_imm || kept_ops[i] == decoder_pkg::sbc_imm)
				compare_strobes($sformatf("op %h write back", kept_ops[i]), 32'(data_ctrl),
					arith_wb, '0);
		end
		apply_vector(3'd1, decoder_pkg::adc_imm, '0, 1'b0, 1'b0);
		compare_strobes("adc cycle 1 addr", 32'(addr_ctrl), bit_at(decoder_pkg::r_cycle),
			bit_at(decoder_pkg::i_cycle));
		compare_strobes("adc cycle 1 data", 32'(data_ctrl), bit_at(decoder_pkg::db_add),
			bit_at(decoder_pkg::ndb_add));
		apply_vector(3'd1, decoder_pkg::sbc_imm, '0, 1'b0, 1'b0);
		compare_strobes("sbc cycle 1 addr", 32'(addr_ctrl), bit_at(decoder_pkg::r_cycle),
			bit_at(decoder_pkg::i_cycle));
		compare_strobes("sbc cycle 1 data", 32'(data_ctrl), bit_at(decoder_pkg::ndb_add),
			bit_at(decoder_pkg::db_add));    // inverted operand
		compare_operand(decoder_pkg::cmp_imm, decoder_pkg::ac_sb);
		compare_operand(decoder_pkg::cpx_imm, decoder_pkg::x_sb);
		compare_operand(decoder_pkg::cpy_imm, decoder_pkg::y_sb);
	endtask

	task automatic single_byte_gate();
		decoder_pkg::opcode_t gate_ops[$];
		int i;
		gate_ops = '{decoder_pkg::inx, decoder_pkg::tax, decoder_pkg::sec, decoder_pkg::pha,
			decoder_pkg::lda_imm};    // last one carries an operand byte
		for (i = 0; i < gate_ops.size(); i++) begin
			apply_vector(3'd0, gate_ops[i], '0, 1'b0, 1'b0);
			drive_inputs(3'd1, gate_ops[i], '0, 1'b0, 1'b0);    // fetch word still held
			compare_level($sformatf("op %h cycle 1 i_pc", gate_ops[i]), i_pc,
				gate_ops[i] == decoder_pkg::lda_imm);
		end
	endtask

	function automatic logic flag_test(input decoder_pkg::opcode_t op,
		input decoder_pkg::status_t s);
		case (op)
			decoder_pkg::bpl: return !s[decoder_pkg::flag_n];
			decoder_pkg::bmi: return s[decoder_pkg::flag_n];
			decoder_pkg::bvc: return !s[decoder_pkg::flag_v];
			decoder_pkg::bvs: return s[decoder_pkg::flag_v];
			decoder_pkg::bcc: return !s[decoder_pkg::flag_c];
			decoder_pkg::bcs: return s[decoder_pkg::flag_c];
			decoder_pkg::bne: return !s[decoder_pkg::flag_z];
			default: return s[decoder_pkg::flag_z];    // beq
		endcase
	endfunction

	task automatic branch_sequences();
		logic [7:0] pv;
		logic [7:0] cs;    // carry in bit 1 and a_sign in bit 0
		logic [31:0] fix;
		int i;
		int k;
		for (i = 0; i < branch_ops.size(); i++) begin
			for (k = 0; k < 4; k++) begin
				random_bits(8, pv);
				random_bits(2, cs);
				apply_vector(3'd1, branch_ops[i], pv, 1'b0, 1'b0);
				if (flag_test(branch_ops[i], pv)) begin
					compare_strobes($sformatf("taken %h p %h addr", branch_ops[i], pv),
						32'(addr_ctrl), bit_at(decoder_pkg::i_cycle), bit_at(decoder_pkg::r_cycle));
					compare_strobes($sformatf("taken %h p %h data", branch_ops[i], pv),
						32'(data_ctrl), bit_at(decoder_pkg::adl_add), '0);
				end else begin
					compare_strobes($sformatf("not taken %h p %h addr", branch_ops[i], pv),
						32'(addr_ctrl), bit_at(decoder_pkg::r_cycle), bit_at(decoder_pkg::i_cycle));
					compare_strobes($sformatf("not taken %h p %h data", branch_ops[i], pv),
						32'(data_ctrl), '0, bit_at(decoder_pkg::adl_add));
				end
				apply_vector(3'd2, branch_ops[i], pv, cs[1], cs[0]);
				fix = bit_at(decoder_pkg::none_add);    // pch minus one on negative offset
				if (cs[1] != cs[0]) begin
					compare_strobes($sformatf("page fix %h addr", branch_ops[i]), 32'(addr_ctrl),
						bit_at(decoder_pkg::i_cycle), bit_at(decoder_pkg::r_cycle));
					compare_strobes($sformatf("page fix %h sign %b data", branch_ops[i], cs[0]),
						32'(data_ctrl), bit_at(decoder_pkg::pch_db) | (cs[0] ? fix : '0),
						cs[0] ? '0 : fix);
				end else begin
					compare_strobes($sformatf("same page %h addr", branch_ops[i]), 32'(addr_ctrl),
						bit_at(decoder_pkg::r_cycle) | bit_at(decoder_pkg::i_pcint),
						bit_at(decoder_pkg::i_cycle));
				end
			end
		end
	endtask

	task automatic push_sequence(input decoder_pkg::opcode_t op, input int unsigned src,
		input int unsigned other);
		apply_vector(3'd1, op, '0, 1'b0, 1'b0);
		compare_level($sformatf("push %h r_nw", op), r_nw, 1'b0);
		compare_strobes($sformatf("push %h stack addr", op), 32'(addr_ctrl),
			bit_at(decoder_pkg::s_adl) | bit_at(decoder_pkg::one_adh), '0);
		compare_strobes($sformatf("push %h source", op), 32'(data_ctrl), bit_at(src),
			bit_at(other));
		apply_vector(3'd2, op, '0, 1'b0, 1'b0);
		compare_strobes($sformatf("push %h d_s", op), 32'(data_ctrl), bit_at(decoder_pkg::d_s), '0);
	endtask

	task automatic stack_and_jump();
		push_sequence(decoder_pkg::pha, decoder_pkg::ac_db, decoder_pkg::p_db);
		push_sequence(decoder_pkg::php, decoder_pkg::p_db, decoder_pkg::ac_db);
		apply_vector(3'd3, decoder_pkg::pla, '0, 1'b0, 1'b0);
		compare_strobes("pla cycle 3 data", 32'(data_ctrl), bit_at(decoder_pkg::sb_ac) |
			bit_at(decoder_pkg::db7_n) | bit_at(decoder_pkg::dbz_z), bit_at(decoder_pkg::db_p));
		apply_vector(3'd3, decoder_pkg::plp, '0, 1'b0, 1'b0);
		compare_strobes("plp cycle 3 data", 32'(data_ctrl), bit_at(decoder_pkg::db_p),
			bit_at(decoder_pkg::sb_ac));
		apply_vector(3'd2, decoder_pkg::jmp_abs, '0, 1'b0, 1'b0);
		compare_strobes("jmp cycle 2 addr", 32'(addr_ctrl), bit_at(decoder_pkg::adl_pcl) |
			bit_at(decoder_pkg::adh_pch) | bit_at(decoder_pkg::dl_adh) |
			bit_at(decoder_pkg::r_cycle), bit_at(decoder_pkg::i_cycle));
	endtask

	task automatic unused_decode();
		decoder_pkg::opcode_t ops[$];
		int i;
		ops = '{8'had, 8'hea, 8'h6c, 8'hb5};    // lda abs, nop, jmp ind, lda zp,x
		for (i = 0; i < ops.size(); i++) begin
			apply_vector(3'd1, ops[i], '0, 1'b0, 1'b0);
			expect_idle($sformatf("op %h cycle 1", ops[i]));
		end
		for (i = 0; i < kept_ops.size(); i += 8) begin
			apply_vector(3'd5, kept_ops[i], '0, 1'b0, 1'b0);
			expect_idle($sformatf("op %h cycle 5", kept_ops[i]));
		end
		for (i = 0; i < 2; i++) begin
			apply_vector(3'd7, i == 0 ? decoder_pkg::adc_imm : 8'hea, '0, 1'b0, 1'b0);
			compare_strobes($sformatf("cycle 7 fetch, pass %0d", i), 32'(addr_ctrl),
				fetch_bits() | bit_at(decoder_pkg::r_cycle), bit_at(decoder_pkg::i_cycle));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// run

	initial begin
		clk_ph2 = 1'b0;
		rst = 1'b0;
		cycle = 3'd1;             // push write decode pending while rst is low
		ir = decoder_pkg::pha;
		p = '0;
		carry = 1'b0;
		a_sign = 1'b0;
		errors = 0;
		lfsr = 32'h4837;
		kept_ops = '{decoder_pkg::adc_imm, decoder_pkg::sbc_imm, decoder_pkg::cmp_imm,
			decoder_pkg::cpx_imm, decoder_pkg::cpy_imm, decoder_pkg::lda_imm, decoder_pkg::ldx_imm,
			decoder_pkg::ldy_imm, decoder_pkg::inx, decoder_pkg::iny, decoder_pkg::dex,
			decoder_pkg::dey, decoder_pkg::tax, decoder_pkg::txa, decoder_pkg::tay,
			decoder_pkg::tya, decoder_pkg::txs, decoder_pkg::tsx, decoder_pkg::sec,
			decoder_pkg::clc, decoder_pkg::pha, decoder_pkg::php, decoder_pkg::pla,
			decoder_pkg::plp, decoder_pkg::jmp_abs, decoder_pkg::bpl, decoder_pkg::bmi,
			decoder_pkg::bvc, decoder_pkg::bvs, decoder_pkg::bcc, decoder_pkg::bcs,
			decoder_pkg::bne, decoder_pkg::beq};
		branch_ops = '{decoder_pkg::bpl, decoder_pkg::bmi, decoder_pkg::bvc, decoder_pkg::bvs,
			decoder_pkg::bcc, decoder_pkg::bcs, decoder_pkg::bne, decoder_pkg::beq};
		reset_state();
		fetch_and_arith();
		single_byte_gate();
		branch_sequences();
		stack_and_jump();
		unused_decode();
		$display("checks done, errors: %0d", errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(test_steps * 100 * 2);    // two clocks per vector
		$display("watchdog expired, the tests did not finish within %0d ns",
			test_steps * 100 * 2);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/decoder_sva.sv ====
`timescale 1ns/1ns

module decoder_sva (
	input logic                    clk_ph2,
	input logic                    rst,
	input decoder_pkg::addr_ctrl_t addr_ctrl,
	input decoder_pkg::data_ctrl_t data_ctrl,
	input logic                    r_nw
);

	//////////////////////////////////////////////////////////////////////
	// registered control word

	// a stack write needs a or p on the data bus
	write_source: assert property (@(posedge clk_ph2) disable iff (!rst)
		!r_nw |-> (data_ctrl[decoder_pkg::ac_db] || data_ctrl[decoder_pkg::p_db]))
		else $error("write cycle with neither ac_db nor p_db set");

	counter_exclusive: assert property (@(posedge clk_ph2) disable iff (!rst)
		!(addr_ctrl[decoder_pkg::i_cycle] && addr_ctrl[decoder_pkg::r_cycle]))
		else $error("i_cycle and r_cycle both set");    // step and restart at once

	operand_exclusive: assert property (@(posedge clk_ph2) disable iff (!rst)
		!(data_ctrl[decoder_pkg::ndb_add] && data_ctrl[decoder_pkg::db_add]))
		else $error("ndb_add and db_add both set");    // alu b input has one source

endmodule

bind instruction_decoder decoder_sva sva0 (
	.clk_ph2   (clk_ph2),
	.rst       (rst),
	.addr_ctrl (addr_ctrl),
	.data_ctrl (data_ctrl),
	.r_nw      (r_nw)
);

// ==== source/instruction_decoder.sv ====
`timescale 1ns/1ns

module instruction_decoder (
	input  logic                    clk_ph2,
	input  logic                    rst,        // sync, active low
	input  decoder_pkg::cycle_t     cycle,      // current instruction cycle
	input  decoder_pkg::opcode_t    ir,         // instruction register
	input  decoder_pkg::status_t    p,          // status register, branch tests
	input  logic                    carry,      // alu carry out
	input  logic                    a_sign,     // alu a-input sign
	output decoder_pkg::addr_ctrl_t addr_ctrl,
	output decoder_pkg::data_ctrl_t data_ctrl,
	output logic                    r_nw,
	output logic                    i_pc
);

	decoder_pkg::instr_class_t instr_class;
	logic                      single_byte;
	logic                      branch_taken;
	logic                      page_cross;
	decoder_pkg::addr_ctrl_t   next_addr;    // decode for the next cycle
	decoder_pkg::data_ctrl_t   next_data;

	opcode_classifier u_classifier (
		.ir           (ir),
		.p            (p),
		.carry        (carry),
		.a_sign       (a_sign),
		.instr_class  (instr_class),
		.single_byte  (single_byte),
		.branch_taken (branch_taken),
		.page_cross   (page_cross)
	);

	bus_sequencer u_bus_seq (
		.cycle        (cycle),
		.instr_class  (instr_class),
		.branch_taken (branch_taken),
		.page_cross   (page_cross),
		.next_addr    (next_addr)
	);

	datapath_decoder u_dp_dec (
		.cycle        (cycle),
		.instr_class  (instr_class),
		.ir           (ir),
		.branch_taken (branch_taken),
		.page_cross   (page_cross),
		.a_sign       (a_sign),
		.next_data    (next_data)
	);

	control_register u_ctrl_reg (
		.clk_ph2     (clk_ph2),
		.rst         (rst),
		.cycle       (cycle),
		.single_byte (single_byte),
		.next_addr   (next_addr),
		.next_data   (next_data),
		.addr_ctrl   (addr_ctrl),
		.data_ctrl   (data_ctrl),
		.r_nw        (r_nw),
		.i_pc        (i_pc)
	);

endmodule

// ==== source/control_register.sv ====
`timescale 1ns/1ns

module control_register (
	input  logic                    clk_ph2,
	input  logic                    rst,          // sync, active low
	input  decoder_pkg::cycle_t     cycle,        // current cycle, for the pc gate
	input  logic                    single_byte,  // current opcode has no operand
	input  decoder_pkg::addr_ctrl_t next_addr,
	input  decoder_pkg::data_ctrl_t next_data,
	output decoder_pkg::addr_ctrl_t addr_ctrl,    // registered address strobes
	output decoder_pkg::data_ctrl_t data_ctrl,    // registered data strobes
	output logic                    r_nw,         // high = read
	output logic                    i_pc          // gated pc increment
);

	// whole word rewritten each edge so no strobe lingers
	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			addr_ctrl <= '0;
			data_ctrl <= '0;
		end else begin
			addr_ctrl <= next_addr;
			data_ctrl <= next_data;
		end
	end

	assign r_nw = ~addr_ctrl[decoder_pkg::wr];    // read after reset

	// operand byte is really the next opcode, keep pc on it
	assign i_pc = addr_ctrl[decoder_pkg::i_pcint] & ~((cycle == 3'd1) && single_byte);

endmodule

// ==== source/datapath_decoder.sv ====
`timescale 1ns/1ns

module datapath_decoder (
	input  decoder_pkg::cycle_t       cycle,         // current instruction cycle
	input  decoder_pkg::instr_class_t instr_class,   // opcode group
	input  decoder_pkg::opcode_t      ir,            // picks the member within a group
	input  logic                      branch_taken,  // branch condition holds
	input  logic                      page_cross,    // pch needs fixing
	input  logic                      a_sign,        // negative offset, pch - 1
	output decoder_pkg::data_ctrl_t   next_data      // data strobes for next cycle
);

	function automatic decoder_pkg::data_ctrl_t dbit(input int unsigned pos);
		return decoder_pkg::data_ctrl_t'(1) << pos;
	endfunction

	localparam decoder_pkg::data_ctrl_t nz_flags =
		dbit(decoder_pkg::db7_n) | dbit(decoder_pkg::dbz_z);    // n and z from db

	logic                    x_sel;     // opcode works on x
	logic                    y_sel;     // opcode works on y
	logic                    to_acc;    // txa / tya
	decoder_pkg::data_ctrl_t reg_sb;    // named register onto sb
	decoder_pkg::data_ctrl_t sb_reg;    // sb into named register

	assign x_sel = ir inside {decoder_pkg::cpx_imm, decoder_pkg::ldx_imm, decoder_pkg::inx,
		decoder_pkg::dex, decoder_pkg::tax, decoder_pkg::txa};
	assign y_sel = ir inside {decoder_pkg::cpy_imm, decoder_pkg::ldy_imm, decoder_pkg::iny,
		decoder_pkg::dey, decoder_pkg::tay, decoder_pkg::tya};
	assign to_acc = ir inside {decoder_pkg::txa, decoder_pkg::tya};
	assign reg_sb = x_sel ? dbit(decoder_pkg::x_sb) :
		y_sel ? dbit(decoder_pkg::y_sb) : dbit(decoder_pkg::ac_sb);    // a by default
	assign sb_reg = x_sel ? dbit(decoder_pkg::sb_x) :
		y_sel ? dbit(decoder_pkg::sb_y) : dbit(decoder_pkg::sb_ac);

	always_comb begin
		next_data = '0;
		case (cycle)
			3'd0: begin    // write back the result of the previous op
				case (instr_class)
					decoder_pkg::cls_arith_imm:
						next_data = dbit(decoder_pkg::add_sb) | dbit(decoder_pkg::sb_ac) |
							dbit(decoder_pkg::sb_db) | dbit(decoder_pkg::avr_v) |
							dbit(decoder_pkg::acr_c) | nz_flags;
					decoder_pkg::cls_compare_imm:
						next_data = dbit(decoder_pkg::acr_c) | nz_flags;    // flags only
					decoder_pkg::cls_inc_dec:
						next_data = dbit(decoder_pkg::add_sb) | dbit(decoder_pkg::sb_db) |
							sb_reg | nz_flags;
					default: ;
				endcase
			end
			3'd1: begin
				case (instr_class)
					decoder_pkg::cls_arith_imm:
						next_data = dbit(decoder_pkg::dl_db) | dbit(decoder_pkg::ac_sb) |
							dbit(decoder_pkg::sb_add) | dbit(decoder_pkg::sums) |
							dbit(ir == decoder_pkg::sbc_imm ? decoder_pkg::ndb_add :
							decoder_pkg::db_add);                          // sbc adds ~operand
					decoder_pkg::cls_compare_imm:
						next_data = dbit(decoder_pkg::dl_db) | dbit(decoder_pkg::ndb_add) |
							dbit(decoder_pkg::sb_add) | dbit(decoder_pkg::sums) |
							dbit(decoder_pkg::c_one) | reg_sb;             // reg - operand
					decoder_pkg::cls_load_imm:
						next_data = dbit(decoder_pkg::dl_db) | dbit(decoder_pkg::db_sb) |
							sb_reg | nz_flags;
					decoder_pkg::cls_inc_dec:
						next_data = reg_sb | dbit(decoder_pkg::sb_db) | dbit(decoder_pkg::db_add) |
							dbit(decoder_pkg::sums) | dbit(decoder_pkg::c_one) |
							dbit(ir inside {decoder_pkg::dex, decoder_pkg::dey} ?
							decoder_pkg::none_add : decoder_pkg::z_add);   // ~1 + 1 or 0 + 1
					decoder_pkg::cls_transfer:
						next_data = nz_flags | (to_acc ?
							reg_sb | dbit(decoder_pkg::sb_db) | dbit(decoder_pkg::sb_ac) :
							dbit(decoder_pkg::ac_sb) | dbit(decoder_pkg::ac_db) | sb_reg);
					decoder_pkg::cls_stack_xfer:
						next_data = (ir == decoder_pkg::txs) ?
							dbit(decoder_pkg::x_sb) | dbit(decoder_pkg::sb_s) :   // no flags
							dbit(decoder_pkg::s_sb) | dbit(decoder_pkg::sb_x) |
							dbit(decoder_pkg::sb_db) | nz_flags;
					decoder_pkg::cls_carry_set:
						next_data = dbit(decoder_pkg::ir5_c);    // c = ir[5], sec vs clc
					decoder_pkg::cls_push:
						next_data = dbit(ir == decoder_pkg::pha ? decoder_pkg::ac_db :
							decoder_pkg::p_db);
					decoder_pkg::cls_pull:
						next_data = dbit(decoder_pkg::i_s);    // pre-increment s
					decoder_pkg::cls_jump_abs:
						next_data = dbit(decoder_pkg::dl_db) | dbit(decoder_pkg::db_add) |
							dbit(decoder_pkg::z_add) | dbit(decoder_pkg::sums) |
							dbit(decoder_pkg::c_zero);             // park adl in the alu
					decoder_pkg::cls_branch:
						if (branch_taken)
							next_data = dbit(decoder_pkg::dl_db) | dbit(decoder_pkg::db_sb) |
								dbit(decoder_pkg::sb_add) | dbit(decoder_pkg::adl_add) |
								dbit(decoder_pkg::c_zero) | dbit(decoder_pkg::sums);  // pcl + offset
					default: ;
				endcase
			end
			3'd2: begin
				if (instr_class == decoder_pkg::cls_push)
					next_data = dbit(decoder_pkg::d_s);    // post-decrement s
				else if (instr_class == decoder_pkg::cls_branch && page_cross)
					next_data = dbit(decoder_pkg::pch_db) | dbit(decoder_pkg::db_add) |
						dbit(decoder_pkg::sums) | dbit(decoder_pkg::c_one) |
						(a_sign ? dbit(decoder_pkg::none_add) : '0);    // pch +1 or -1
			end
			3'd3: begin
				if (instr_class == decoder_pkg::cls_branch)
					next_data = dbit(decoder_pkg::add_sb);    // fixed pch toward sb_adh
				else if (instr_class == decoder_pkg::cls_pull)
					next_data = dbit(decoder_pkg::dl_db) | ((ir == decoder_pkg::pla) ?
						dbit(decoder_pkg::db_sb) | dbit(decoder_pkg::sb_ac) | nz_flags :
						dbit(decoder_pkg::db_p));
			end
			default: ;    // cycle 7 fetch has no data-side work
		endcase
	end

endmodule

// ==== source/bus_sequencer.sv ====
`timescale 1ns/1ns

module bus_sequencer (
	input  decoder_pkg::cycle_t       cycle,         // current instruction cycle
	input  decoder_pkg::instr_class_t instr_class,   // opcode group
	input  logic                      branch_taken,  // branch condition holds
	input  logic                      page_cross,    // branch target in next/prev page
	output decoder_pkg::addr_ctrl_t   next_addr      // address strobes for next cycle
);

	function automatic decoder_pkg::addr_ctrl_t abit(input int unsigned pos);
		return decoder_pkg::addr_ctrl_t'(1) << pos;    // one strobe set
	endfunction

	// pc onto the address bus and step it
	localparam decoder_pkg::addr_ctrl_t pc_fetch =
		abit(decoder_pkg::pcl_adl) | abit(decoder_pkg::adl_abl) |
		abit(decoder_pkg::pch_adh) | abit(decoder_pkg::adh_abh) |
		abit(decoder_pkg::i_pcint) | abit(decoder_pkg::pcl_pcl) |
		abit(decoder_pkg::pch_pch);

	// {0x01, s} onto the address bus
	localparam decoder_pkg::addr_ctrl_t stack_addr =
		abit(decoder_pkg::s_adl) | abit(decoder_pkg::adl_abl) |
		abit(decoder_pkg::one_adh) | abit(decoder_pkg::adh_abh);

	always_comb begin
		next_addr = '0;    // idle unless a sequence below claims the cycle
		case (cycle)
			3'd0: begin
				if (instr_class != decoder_pkg::cls_other)
					next_addr = pc_fetch | abit(decoder_pkg::i_cycle);    // fetch operand
			end
			3'd1: begin
				case (instr_class)
					decoder_pkg::cls_arith_imm, decoder_pkg::cls_compare_imm,
					decoder_pkg::cls_load_imm, decoder_pkg::cls_inc_dec,
					decoder_pkg::cls_transfer, decoder_pkg::cls_stack_xfer,
					decoder_pkg::cls_carry_set:
						next_addr = pc_fetch | abit(decoder_pkg::r_cycle);    // next opcode
					decoder_pkg::cls_push:
						next_addr = stack_addr | abit(decoder_pkg::i_cycle) |
							abit(decoder_pkg::wr);                             // write to stack
					decoder_pkg::cls_pull:
						next_addr = stack_addr | abit(decoder_pkg::i_cycle);  // dummy stack read
					decoder_pkg::cls_jump_abs:
						next_addr = pc_fetch | abit(decoder_pkg::i_cycle);    // fetch adh
					decoder_pkg::cls_branch:
						next_addr = pc_fetch | abit(branch_taken ? decoder_pkg::i_cycle :
							decoder_pkg::r_cycle);                             // not taken ends here
					default: ;
				endcase
			end
			3'd2: begin
				case (instr_class)
					decoder_pkg::cls_jump_abs:
						next_addr = abit(decoder_pkg::r_cycle) | abit(decoder_pkg::i_pcint) |
							abit(decoder_pkg::add_adl) | abit(decoder_pkg::adl_abl) |
							abit(decoder_pkg::adl_pcl) | abit(decoder_pkg::dl_adh) |
							abit(decoder_pkg::adh_abh) | abit(decoder_pkg::adh_pch);  // pc = target
					decoder_pkg::cls_branch:
						next_addr = abit(decoder_pkg::add_adl) | abit(decoder_pkg::adl_abl) |
							abit(decoder_pkg::adl_pcl) | abit(decoder_pkg::pch_adh) |
							abit(decoder_pkg::adh_abh) |                            // {pcl+off, pch}
							(page_cross ? abit(decoder_pkg::i_cycle) :
							abit(decoder_pkg::r_cycle) | abit(decoder_pkg::i_pcint));
					decoder_pkg::cls_pull:
						next_addr = abit(decoder_pkg::i_cycle) | abit(decoder_pkg::s_adl) |
							abit(decoder_pkg::adl_abl);                       // abh still holds 0x01
					decoder_pkg::cls_push:
						next_addr = pc_fetch | abit(decoder_pkg::r_cycle);
					default: ;
				endcase
			end
			3'd3: begin
				case (instr_class)
					decoder_pkg::cls_branch:
						next_addr = abit(decoder_pkg::r_cycle) | abit(decoder_pkg::i_pcint) |
							abit(decoder_pkg::sb_adh) | abit(decoder_pkg::adh_abh) |
							abit(decoder_pkg::adh_pch);                        // fixed pch out
					decoder_pkg::cls_pull:
						next_addr = pc_fetch | abit(decoder_pkg::r_cycle);
					default: ;
				endcase
			end
			3'd7: next_addr = pc_fetch | abit(decoder_pkg::r_cycle);    // recover to fetch
			default: ;                                                   // cycles 4..6 unused
		endcase
	end

endmodule

// ==== source/opcode_classifier.sv ====
`timescale 1ns/1ns

module opcode_classifier (
	input  decoder_pkg::opcode_t      ir,            // current opcode
	input  decoder_pkg::status_t      p,             // status register
	input  logic                      carry,         // alu carry out
	input  logic                      a_sign,        // sign of branch offset
	output decoder_pkg::instr_class_t instr_class,   // opcode group
	output logic                      single_byte,   // no operand byte follows
	output logic                      branch_taken,  // branch condition holds
	output logic                      page_cross     // pcl + offset left the page
);

	logic flag_sel;    // status bit named by the branch opcode

	always_comb begin
		case (ir)
			decoder_pkg::adc_imm, decoder_pkg::sbc_imm:
				instr_class = decoder_pkg::cls_arith_imm;
			decoder_pkg::cmp_imm, decoder_pkg::cpx_imm, decoder_pkg::cpy_imm:
				instr_class = decoder_pkg::cls_compare_imm;
			decoder_pkg::lda_imm, decoder_pkg::ldx_imm, decoder_pkg::ldy_imm:
				instr_class = decoder_pkg::cls_load_imm;
			decoder_pkg::inx, decoder_pkg::iny, decoder_pkg::dex, decoder_pkg::dey:
				instr_class = decoder_pkg::cls_inc_dec;
			decoder_pkg::tax, decoder_pkg::txa, decoder_pkg::tay, decoder_pkg::tya:
				instr_class = decoder_pkg::cls_transfer;
			decoder_pkg::txs, decoder_pkg::tsx:
				instr_class = decoder_pkg::cls_stack_xfer;
			decoder_pkg::sec, decoder_pkg::clc:
				instr_class = decoder_pkg::cls_carry_set;
			decoder_pkg::pha, decoder_pkg::php:
				instr_class = decoder_pkg::cls_push;
			decoder_pkg::pla, decoder_pkg::plp:
				instr_class = decoder_pkg::cls_pull;
			decoder_pkg::jmp_abs:
				instr_class = decoder_pkg::cls_jump_abs;
			decoder_pkg::bpl, decoder_pkg::bmi, decoder_pkg::bvc, decoder_pkg::bvs,
			decoder_pkg::bcc, decoder_pkg::bcs, decoder_pkg::bne, decoder_pkg::beq:
				instr_class = decoder_pkg::cls_branch;
			default:
				instr_class = decoder_pkg::cls_other;    // addressing modes not decoded
		endcase
	end

	// bits 7:6 of a branch pick the flag and bit 5 is the value that takes it
	always_comb begin
		case (ir[7:6])
			2'b00:   flag_sel = p[decoder_pkg::flag_n];    // bpl / bmi
			2'b01:   flag_sel = p[decoder_pkg::flag_v];    // bvc / bvs
			2'b10:   flag_sel = p[decoder_pkg::flag_c];    // bcc / bcs
			default: flag_sel = p[decoder_pkg::flag_z];    // bne / beq
		endcase
	end

	assign single_byte = instr_class inside {decoder_pkg::cls_inc_dec, decoder_pkg::cls_transfer,
		decoder_pkg::cls_stack_xfer, decoder_pkg::cls_carry_set, decoder_pkg::cls_push,
		decoder_pkg::cls_pull};    // implied and stack ops
	assign branch_taken = (instr_class == decoder_pkg::cls_branch) && (flag_sel == ir[5]);
	assign page_cross = carry ^ a_sign;    // carry or borrow into pch

endmodule

// ==== source/decoder_pkg.sv ====
package decoder_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and vector types

	localparam int unsigned addr_ctrl_w = 17;    // address-side strobe count
	localparam int unsigned data_ctrl_w = 32;    // data-side strobe count

	typedef logic [7:0]             opcode_t;     // instruction register value
	typedef logic [2:0]             cycle_t;      // instruction cycle 0..7
	typedef logic [7:0]             status_t;     // processor status register
	typedef logic [addr_ctrl_w-1:0] addr_ctrl_t;  // address, pc and sequencing strobes
	typedef logic [data_ctrl_w-1:0] data_ctrl_t;  // bus, register, alu and flag strobes

	// status register bits tested by branches
	localparam int unsigned flag_n = 7, flag_v = 6, flag_z = 1, flag_c = 0;

	//////////////////////////////////////////////////////////////////////
	// strobe bit positions

	localparam int unsigned
		i_cycle = 0, r_cycle = 1,                              // counter step / restart
		pcl_adl = 2, pch_adh = 3, adl_abl = 4, adh_abh = 5,    // pc onto address bus
		pcl_pcl = 6, pch_pch = 7, adl_pcl = 8, adh_pch = 9,    // pc hold or load
		add_adl = 10, dl_adh = 11, sb_adh = 12,                // other address sources
		s_adl = 13, one_adh = 14,                              // stack page 0x01xx
		i_pcint = 15,                                          // raw pc increment request
		wr = 16;                                               // write, r_nw is its inverse

	localparam int unsigned
		dl_db = 0, ac_sb = 1, ac_db = 2, add_sb = 3,           // data and special buses
		pch_db = 4, p_db = 5, sb_ac = 6, sb_db = 7,
		sb_x = 8, sb_y = 9, x_sb = 10, y_sb = 11, db_sb = 12,  // index registers
		sb_s = 13, s_sb = 14, i_s = 15, d_s = 16,              // stack pointer
		sb_add = 17, ndb_add = 18, db_add = 19, z_add = 20,    // alu operand selects
		c_one = 21, none_add = 22, adl_add = 23, c_zero = 24,
		sums = 25,                                             // alu add operation
		avr_v = 26, acr_c = 27, dbz_z = 28, db7_n = 29,        // status flag loads
		ir5_c = 30, db_p = 31;

	// instruction groups, one sequence per group
	typedef enum logic [3:0] {
		cls_arith_imm,      // adc / sbc
		cls_compare_imm,    // cmp / cpx / cpy
		cls_load_imm,       // lda / ldx / ldy
		cls_inc_dec,
		cls_transfer,       // a <-> x / y
		cls_stack_xfer,     // txs / tsx
		cls_carry_set,      // sec / clc
		cls_push,
		cls_pull,
		cls_jump_abs,
		cls_branch,
		cls_other
	} instr_class_t;

	//////////////////////////////////////////////////////////////////////
	// opcodes

	localparam opcode_t
		adc_imm = 8'h69, sbc_imm = 8'he9,
		cmp_imm = 8'hc9, cpx_imm = 8'he0, cpy_imm = 8'hc0,
		lda_imm = 8'ha9, ldx_imm = 8'ha2, ldy_imm = 8'ha0,
		inx = 8'he8, iny = 8'hc8, dex = 8'hca, dey = 8'h88,
		tax = 8'haa, txa = 8'h8a, tay = 8'ha8, tya = 8'h98,
		txs = 8'h9a, tsx = 8'hba, sec = 8'h38, clc = 8'h18,
		pha = 8'h48, php = 8'h08, pla = 8'h68, plp = 8'h28,
		jmp_abs = 8'h4c,
		bpl = 8'h10, bmi = 8'h30, bvc = 8'h50, bvs = 8'h70,
		bcc = 8'h90, bcs = 8'hb0, bne = 8'hd0, beq = 8'hf0;

endpackage
